/* banked_mem.f */
+incdir+.
mem_geom_pkg.sv
mem_port_pkg.sv
bank_ram.sv
lane_rotator.sv
access_controller.sv
bank_group_array.sv
read_return.sv
banked_mem.sv
banked_mem_assertions.sv
banked_mem_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= banked_mem_tb
FILELIST  ?= banked_mem.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "RESULT: FAIL"; exit 1; \
	elif ! grep -q "Finished with no errors" $(LOG); then \
		echo "RESULT: FAIL, simulation stopped early"; exit 1; \
	else \
		echo "RESULT: PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* banked_mem_tb.sv */
`timescale 1ns/1ps
`include "banked_mem_defines.svh"

module banked_mem_tb;

    localparam int NP           = `MEM_NUM_PORTS;
    localparam int BPT          = `MEM_BANKS_PER_THREAD;
    localparam int REGION_WORDS = 2 ** $bits(mem_geom_pkg::mem_word_ofs_t);
    localparam int DRAIN        = `MEM_RD_LATENCY + 2;
    // reset, idle, aligned, unaligned, wrap, parallel, read after write, back to back
    localparam int TEST_CYCLES  = 8 + 20 + 16 + 24 + 6 + 2 + 4 + 10 + 7 * DRAIN;
    localparam int unsigned TIMEOUT_CYCLES = TEST_CYCLES + 200;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    we [NP-1:0];
    logic                    re [NP-1:0];
    mem_port_pkg::mem_addr_t addr [NP-1:0];
    mem_geom_pkg::mem_line_t wdata [NP-1:0];
    logic                    rd_rdy [NP-1:0];
    mem_geom_pkg::mem_line_t rdata [NP-1:0];

    // model of every region at word granularity
    mem_geom_pkg::mem_word_t     model_mem [`MEM_NUM_THREADS][REGION_WORDS];
    mem_geom_pkg::mem_line_t     exp_line_q [NP][$];
    int unsigned                 exp_cyc_q [NP][$];
    mem_geom_pkg::mem_word_ofs_t wrap_ofs [6] = '{8'd0, 8'd252, 8'd254, 8'd254, 8'd0, 8'd252};
    int unsigned                 cycle = 0;
    string                       test_name = "reset";

    banked_mem dut_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .we     (we),
        .re     (re),
        .addr   (addr),
        .wdata  (wdata),
        .rd_rdy (rd_rdy),
        .rdata  (rdata)
    );

    always #4 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    // word k of the line lives at ofs+k and wraps inside the region
    function automatic mem_geom_pkg::mem_line_t ref_access(
        input logic                        wr,
        input mem_port_pkg::mem_thread_t   thr,
        input mem_geom_pkg::mem_word_ofs_t ofs,
        input mem_geom_pkg::mem_line_t     line
    );
        mem_geom_pkg::mem_line_t     result;
        mem_geom_pkg::mem_word_ofs_t w;
        for (int k = 0; k < BPT; k++) begin
            w = ofs + mem_geom_pkg::mem_word_ofs_t'(k);
            if (wr) begin
                model_mem[thr][w] = line[k*32 +: 32];
            end
            result[k*32 +: 32] = model_mem[thr][w];
        end
        return result;
    endfunction

    // byte bits are ignored by the DUT, so fill them randomly
    function automatic mem_port_pkg::mem_addr_t make_addr(
        input mem_port_pkg::mem_thread_t   thr,
        input mem_geom_pkg::mem_word_ofs_t ofs
    );
        return {thr, ofs, 2'($urandom)};
    endfunction

    function automatic mem_port_pkg::mem_thread_t spread_thread(
        input mem_port_pkg::mem_thread_t base,
        input int                        p
    );
        return mem_port_pkg::mem_thread_t'(base + 2 * p);
    endfunction

    task automatic put_write(input int p, input mem_port_pkg::mem_thread_t thr,
                             input mem_geom_pkg::mem_word_ofs_t ofs);
        mem_geom_pkg::mem_line_t line;
        line = {$urandom, $urandom, $urandom, $urandom};
        void'(ref_access(1'b1, thr, ofs, line));
        we[p]    = 1'b1;
        addr[p]  = make_addr(thr, ofs);
        wdata[p] = line;
    endtask

    task automatic put_read(input int p, input mem_port_pkg::mem_thread_t thr,
                            input mem_geom_pkg::mem_word_ofs_t ofs);
        re[p]   = 1'b1;
        addr[p] = make_addr(thr, ofs);
        exp_line_q[p].push_back(ref_access(1'b0, thr, ofs, '0));
        exp_cyc_q[p].push_back(cycle + `MEM_RD_LATENCY);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
        for (int p = 0; p < NP; p++) begin
            we[p] = 1'b0;
            re[p] = 1'b0;
        end
    endtask

    task automatic write_read_line(input int p, input logic [1:0] lo);
        mem_port_pkg::mem_thread_t   thr;
        mem_geom_pkg::mem_word_ofs_t ofs;
        thr      = mem_port_pkg::mem_thread_t'($urandom);
        ofs      = mem_geom_pkg::mem_word_ofs_t'($urandom);
        ofs[1:0] = lo;
        put_write(p, thr, ofs);
        next_cycle();
        put_read(p, thr, ofs);
        next_cycle();
    endtask

    task automatic wait_reads_done();
        int pending;
        pending = 1;
        while (pending != 0) begin
            next_cycle();
            pending = 0;
            for (int p = 0; p < NP; p++) begin
                pending += exp_line_q[p].size();
            end
        end
    endtask

    // rd_rdy and rdata are stable at the falling edge
    always @(negedge clk) begin
        mem_geom_pkg::mem_line_t exp_line;
        int unsigned             exp_cyc;
        for (int p = 0; p < NP; p++) begin
            if (rd_rdy[p]) begin
                assert (exp_line_q[p].size() > 0)
                    else fail_run($sformatf("port %0d raised rd_rdy with no read pending in %s",
                                            p, test_name));
                exp_line = exp_line_q[p].pop_front();
                exp_cyc  = exp_cyc_q[p].pop_front();
                assert (cycle == exp_cyc)
                    else fail_run($sformatf("[ERROR] %s port %0d expected cycle %0d actual %0d",
                                            test_name, p, exp_cyc, cycle));
                assert (rdata[p] === exp_line)
                    else fail_run($sformatf("[ERROR] %s port %0d expected %h actual %h",
                                            test_name, p, exp_line, rdata[p]));
            end else if (exp_cyc_q[p].size() > 0) begin
                assert (exp_cyc_q[p][0] != cycle)
                    else fail_run($sformatf("port %0d missed its rd_rdy in cycle %0d during %s",
                                            p, cycle, test_name));
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout, run did not finish within %0d cycles",
                               TIMEOUT_CYCLES));
        end
    end

    initial begin
        mem_port_pkg::mem_thread_t   base;
        mem_geom_pkg::mem_word_ofs_t ofs;

        void'($urandom(32'hd378));
        rst_n = 1'b0;
        for (int p = 0; p < NP; p++) begin
            we[p]    = 1'b0;
            re[p]    = 1'b0;
            addr[p]  = '0;
            wdata[p] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // no requests here so any rd_rdy is flagged by the checker
        test_name = "idle_after_reset";
        repeat (20) next_cycle();

        test_name = "aligned_lines";
        for (int i = 0; i < 8; i++) begin
            write_read_line(i % NP, 2'd0);
        end
        wait_reads_done();

        test_name = "unaligned_offsets";
        for (int i = 0; i < 12; i++) begin
            write_read_line(i % NP, 2'(i / NP + 1));
        end
        wait_reads_done();

        // lines at 0 and 252 first, so the wrapped write is visible in both
        test_name = "wrap_254";
        base = mem_port_pkg::mem_thread_t'($urandom);
        for (int s = 0; s < 6; s++) begin
            for (int p = 0; p < NP; p++) begin
                if (s < 3) begin
                    put_write(p, spread_thread(base, p), wrap_ofs[s]);
                end else begin
                    put_read(p, spread_thread(base, p), wrap_ofs[s]);
                end
            end
            next_cycle();
        end
        wait_reads_done();

        test_name = "parallel_ports";
        base = mem_port_pkg::mem_thread_t'($urandom);
        ofs  = mem_geom_pkg::mem_word_ofs_t'($urandom);
        for (int p = 0; p < NP; p++) begin
            put_write(p, spread_thread(base, p), ofs);
        end
        next_cycle();
        // each port reads the line its neighbour wrote
        for (int p = 0; p < NP; p++) begin
            put_read(p, spread_thread(base, (p + 1) % NP), ofs);
        end
        next_cycle();
        wait_reads_done();

        test_name = "read_after_write";
        base = mem_port_pkg::mem_thread_t'($urandom);
        ofs  = mem_geom_pkg::mem_word_ofs_t'($urandom);
        for (int r = 0; r < 2; r++) begin
            for (int p = 0; p < NP; p++) begin
                put_write(p, spread_thread(base, p), ofs);
            end
            next_cycle();
            for (int p = 0; p < NP; p++) begin
                put_read(p, spread_thread(base, p), ofs);
            end
            next_cycle();
        end
        wait_reads_done();

        test_name = "back_to_back_reads";
        for (int j = 0; j < 10; j++) begin
            for (int p = 0; p < NP; p++) begin
                if (j < 5) begin
                    put_write(p, spread_thread(base, p),
                              mem_geom_pkg::mem_word_ofs_t'(ofs + 4 * j));
                end else begin
                    put_read(p, spread_thread(base, p),
                             mem_geom_pkg::mem_word_ofs_t'(ofs + 4 * (j - 5)));
                end
            end
            next_cycle();
        end
        wait_reads_done();

        // any late or extra rd_rdy shows up in the checker
        test_name = "quiet_tail";
        repeat (DRAIN) next_cycle();
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* banked_mem_assertions.sv */
`timescale 1ns/1ps
`include "banked_mem_defines.svh"

module banked_mem_assertions (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    we [`MEM_NUM_PORTS-1:0],
    input  logic                    re [`MEM_NUM_PORTS-1:0],
    input  mem_port_pkg::mem_addr_t addr [`MEM_NUM_PORTS-1:0],
    input  logic                    rd_rdy [`MEM_NUM_PORTS-1:0]
);

    localparam int THR_W   = $bits(mem_port_pkg::mem_thread_t);
    localparam int THR_LSB = $bits(mem_port_pkg::mem_addr_t) - THR_W;

    for (genvar p = 0; p < `MEM_NUM_PORTS; p++) begin : g_port
        // one strobe per port per cycle
        a_no_rw: assert property (@(posedge clk) disable iff (!rst_n)
            !(we[p] && re[p]))
            else $error("port %0d raised we and re in the same cycle", p);

        a_rd_latency: assert property (@(posedge clk) disable iff (!rst_n)
            rd_rdy[p] == $past(re[p], `MEM_RD_LATENCY))
            else $error("port %0d rd_rdy does not follow re by the read latency", p);

        // thread collision between two active ports
        for (genvar q = p + 1; q < `MEM_NUM_PORTS; q++) begin : g_other
            a_thread_conflict: assert property (@(posedge clk) disable iff (!rst_n)
                !((we[p] || re[p]) && (we[q] || re[q]) &&
                  addr[p][THR_LSB +: THR_W] == addr[q][THR_LSB +: THR_W]))
                else $error("ports %0d and %0d address the same thread", p, q);
        end
    end

endmodule

bind banked_mem banked_mem_assertions assertions_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .we     (we),
    .re     (re),
    .addr   (addr),
    .rd_rdy (rd_rdy)
);

/* banked_mem.sv */
`timescale 1ns/1ps
`include "banked_mem_defines.svh"

module banked_mem (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    we [`MEM_NUM_PORTS-1:0],
    input  logic                    re [`MEM_NUM_PORTS-1:0],
    input  mem_port_pkg::mem_addr_t addr [`MEM_NUM_PORTS-1:0],
    input  mem_geom_pkg::mem_line_t wdata [`MEM_NUM_PORTS-1:0],
    output logic                    rd_rdy [`MEM_NUM_PORTS-1:0],
    output mem_geom_pkg::mem_line_t rdata [`MEM_NUM_PORTS-1:0]
);

    // stage 0, per port
    mem_geom_pkg::mem_row_t        row_s0 [`MEM_NUM_PORTS-1:0][`MEM_BANKS_PER_THREAD-1:0];
    mem_geom_pkg::mem_word_t       data_s0 [`MEM_NUM_PORTS-1:0][`MEM_BANKS_PER_THREAD-1:0];
    mem_port_pkg::mem_thread_t     thread_s0 [`MEM_NUM_PORTS-1:0];
    mem_geom_pkg::mem_bank_idx_t   start_bank_s0 [`MEM_NUM_PORTS-1:0];
    logic                          we_s0 [`MEM_NUM_PORTS-1:0];
    logic                          active_s0 [`MEM_NUM_PORTS-1:0];

    // per thread control
    mem_port_pkg::mem_port_idx_t   owner_s0 [`MEM_NUM_THREADS-1:0];
    logic                          bank_we_s1 [`MEM_NUM_THREADS-1:0];

    // return path
    mem_port_pkg::mem_thread_t     thread_s2 [`MEM_NUM_PORTS-1:0];
    mem_geom_pkg::mem_bank_idx_t   start_bank_s2 [`MEM_NUM_PORTS-1:0];
    mem_geom_pkg::mem_word_t       q_s2 [`MEM_NUM_THREADS-1:0][`MEM_BANKS_PER_THREAD-1:0];

    lane_rotator lane_rotator_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .we            (we),
        .re            (re),
        .addr          (addr),
        .wdata         (wdata),
        .row_s0        (row_s0),
        .data_s0       (data_s0),
        .thread_s0     (thread_s0),
        .start_bank_s0 (start_bank_s0),
        .we_s0         (we_s0),
        .active_s0     (active_s0)
    );

    access_controller access_controller_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .re            (re),
        .thread_s0     (thread_s0),
        .start_bank_s0 (start_bank_s0),
        .we_s0         (we_s0),
        .active_s0     (active_s0),
        .owner_s0      (owner_s0),
        .bank_we_s1    (bank_we_s1),
        .thread_s2     (thread_s2),
        .start_bank_s2 (start_bank_s2),
        .rd_rdy        (rd_rdy)
    );

    bank_group_array bank_group_array_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .row_s0     (row_s0),
        .data_s0    (data_s0),
        .owner_s0   (owner_s0),
        .bank_we_s1 (bank_we_s1),
        .q_s2       (q_s2)
    );

    read_return read_return_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .q_s2          (q_s2),
        .thread_s2     (thread_s2),
        .start_bank_s2 (start_bank_s2),
        .rdata         (rdata)
    );

endmodule

/* read_return.sv */
`timescale 1ns/1ps
`include "banked_mem_defines.svh"

module read_return (
    input  logic                        clk,
    input  logic                        rst_n,
    input  mem_geom_pkg::mem_word_t     q_s2 [`MEM_NUM_THREADS-1:0][`MEM_BANKS_PER_THREAD-1:0],
    input  mem_port_pkg::mem_thread_t   thread_s2 [`MEM_NUM_PORTS-1:0],
    input  mem_geom_pkg::mem_bank_idx_t start_bank_s2 [`MEM_NUM_PORTS-1:0],
    output mem_geom_pkg::mem_line_t     rdata [`MEM_NUM_PORTS-1:0]
);

    localparam int WORD_W = $bits(mem_geom_pkg::mem_word_t);

    for (genvar p = 0; p < `MEM_NUM_PORTS; p++) begin : g_port
        mem_geom_pkg::mem_word_t     line_s3 [`MEM_BANKS_PER_THREAD-1:0];
        mem_geom_pkg::mem_word_t     line_s4 [`MEM_BANKS_PER_THREAD-1:0];
        mem_geom_pkg::mem_bank_idx_t start_s3;
        mem_geom_pkg::mem_bank_idx_t start_s4;

        // banks still in bank order here
        always_ff @(posedge clk) begin
            for (int b = 0; b < `MEM_BANKS_PER_THREAD; b++) begin
                line_s3[b] <= q_s2[thread_s2[p]][b];
                line_s4[b] <= line_s3[b];
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                start_s3 <= '0;
                start_s4 <= '0;
            end else begin
                start_s3 <= start_bank_s2[p];
                start_s4 <= start_s3;
            end
        end

        // lane k comes from bank start+k, wrapping
        always_comb begin
            for (int k = 0; k < `MEM_BANKS_PER_THREAD; k++) begin
                rdata[p][k*WORD_W +: WORD_W] =
                    line_s4[start_s4 + mem_geom_pkg::mem_bank_idx_t'(k)];
            end
        end
    end

endmodule

/* bank_group_array.sv */
`timescale 1ns/1ps
`include "banked_mem_defines.svh"

module bank_group_array (
    input  logic                        clk,
    input  logic                        rst_n,
    input  mem_geom_pkg::mem_row_t      row_s0 [`MEM_NUM_PORTS-1:0][`MEM_BANKS_PER_THREAD-1:0],
    input  mem_geom_pkg::mem_word_t     data_s0 [`MEM_NUM_PORTS-1:0][`MEM_BANKS_PER_THREAD-1:0],
    input  mem_port_pkg::mem_port_idx_t owner_s0 [`MEM_NUM_THREADS-1:0],
    input  logic                        bank_we_s1 [`MEM_NUM_THREADS-1:0],
    output mem_geom_pkg::mem_word_t     q_s2 [`MEM_NUM_THREADS-1:0][`MEM_BANKS_PER_THREAD-1:0]
);

    for (genvar t = 0; t < `MEM_NUM_THREADS; t++) begin : g_thread
        for (genvar b = 0; b < `MEM_BANKS_PER_THREAD; b++) begin : g_bank
            mem_geom_pkg::mem_row_t  row_s1;
            mem_geom_pkg::mem_word_t data_s1;

            // the owning port steers this bank for one cycle
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    row_s1 <= '0;
                end else begin
                    row_s1 <= row_s0[owner_s0[t]][b];
                end
            end

            always_ff @(posedge clk) begin
                data_s1 <= data_s0[owner_s0[t]][b];
            end

            bank_ram bank_i (
                .clk  (clk),
                .we   (bank_we_s1[t]),
                .row  (row_s1),
                .data (data_s1),
                .q    (q_s2[t][b])
            );
        end
    end

endmodule

/* access_controller.sv */
`timescale 1ns/1ps
`include "banked_mem_defines.svh"

module access_controller (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          re [`MEM_NUM_PORTS-1:0],
    input  mem_port_pkg::mem_thread_t     thread_s0 [`MEM_NUM_PORTS-1:0],
    input  mem_geom_pkg::mem_bank_idx_t   start_bank_s0 [`MEM_NUM_PORTS-1:0],
    input  logic                          we_s0 [`MEM_NUM_PORTS-1:0],
    input  logic                          active_s0 [`MEM_NUM_PORTS-1:0],
    output mem_port_pkg::mem_port_idx_t   owner_s0 [`MEM_NUM_THREADS-1:0],
    output logic                          bank_we_s1 [`MEM_NUM_THREADS-1:0],
    output mem_port_pkg::mem_thread_t     thread_s2 [`MEM_NUM_PORTS-1:0],
    output mem_geom_pkg::mem_bank_idx_t   start_bank_s2 [`MEM_NUM_PORTS-1:0],
    output logic                          rd_rdy [`MEM_NUM_PORTS-1:0]
);

    for (genvar t = 0; t < `MEM_NUM_THREADS; t++) begin : g_thread
        logic owned;

        // lowest active port on this thread wins, so scan from the top
        always_comb begin
            owner_s0[t] = '0;
            owned       = 1'b0;
            for (int p = `MEM_NUM_PORTS - 1; p >= 0; p--) begin
                if (active_s0[p] && thread_s0[p] == mem_port_pkg::mem_thread_t'(t)) begin
                    owner_s0[t] = mem_port_pkg::mem_port_idx_t'(p);
                    owned       = 1'b1;
                end
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                bank_we_s1[t] <= 1'b0;
            end else begin
                bank_we_s1[t] <= owned & we_s0[owner_s0[t]];
            end
        end
    end

    for (genvar p = 0; p < `MEM_NUM_PORTS; p++) begin : g_port
        mem_port_pkg::mem_thread_t   thread_s1;
        mem_geom_pkg::mem_bank_idx_t start_s1;
        logic                        rd_pipe [`MEM_RD_LATENCY-1:0];

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                thread_s1        <= '0;
                thread_s2[p]     <= '0;
                start_s1         <= '0;
                start_bank_s2[p] <= '0;
                for (int i = 0; i < `MEM_RD_LATENCY; i++) begin
                    rd_pipe[i] <= 1'b0;
                end
            end else begin
                // line select runs one stage behind the bank answer
                thread_s1        <= thread_s0[p];
                thread_s2[p]     <= thread_s1;
                start_s1         <= start_bank_s0[p];
                start_bank_s2[p] <= start_s1;
                rd_pipe[0]       <= re[p];
                for (int i = 1; i < `MEM_RD_LATENCY; i++) begin
                    rd_pipe[i] <= rd_pipe[i-1];
                end
            end
        end

        assign rd_rdy[p] = rd_pipe[`MEM_RD_LATENCY-1];
    end

endmodule

/* lane_rotator.sv */
`timescale 1ns/1ps
`include "banked_mem_defines.svh"

module lane_rotator (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          we [`MEM_NUM_PORTS-1:0],
    input  logic                          re [`MEM_NUM_PORTS-1:0],
    input  mem_port_pkg::mem_addr_t       addr [`MEM_NUM_PORTS-1:0],
    input  mem_geom_pkg::mem_line_t       wdata [`MEM_NUM_PORTS-1:0],
    output mem_geom_pkg::mem_row_t        row_s0 [`MEM_NUM_PORTS-1:0][`MEM_BANKS_PER_THREAD-1:0],
    output mem_geom_pkg::mem_word_t       data_s0 [`MEM_NUM_PORTS-1:0][`MEM_BANKS_PER_THREAD-1:0],
    output mem_port_pkg::mem_thread_t     thread_s0 [`MEM_NUM_PORTS-1:0],
    output mem_geom_pkg::mem_bank_idx_t   start_bank_s0 [`MEM_NUM_PORTS-1:0],
    output logic                          we_s0 [`MEM_NUM_PORTS-1:0],
    output logic                          active_s0 [`MEM_NUM_PORTS-1:0]
);

    localparam int OFS_W  = $bits(mem_geom_pkg::mem_word_ofs_t);
    localparam int THR_W  = $bits(mem_port_pkg::mem_thread_t);
    localparam int WORD_W = $bits(mem_geom_pkg::mem_word_t);

    for (genvar p = 0; p < `MEM_NUM_PORTS; p++) begin : g_port
        mem_geom_pkg::mem_word_ofs_t ofs;
        mem_geom_pkg::mem_bank_idx_t start;

        assign ofs   = addr[p][2 +: OFS_W];
        assign start = ofs[1:0];

        for (genvar b = 0; b < `MEM_BANKS_PER_THREAD; b++) begin : g_bank
            // which word of the line lands in this bank
            mem_geom_pkg::mem_bank_idx_t lane;
            mem_geom_pkg::mem_word_ofs_t word;

            assign lane = mem_geom_pkg::mem_bank_idx_t'(b) - start;
            // wraps at the end of the region
            assign word = ofs + mem_geom_pkg::mem_word_ofs_t'(lane);

            always_ff @(posedge clk) begin
                row_s0[p][b]  <= word[OFS_W-1:2];
                data_s0[p][b] <= wdata[p][lane*WORD_W +: WORD_W];
            end
        end

        always_ff @(posedge clk) begin
            thread_s0[p]     <= addr[p][2+OFS_W +: THR_W];
            start_bank_s0[p] <= start;
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                we_s0[p]     <= 1'b0;
                active_s0[p] <= 1'b0;
            end else begin
                we_s0[p]     <= we[p];
                active_s0[p] <= we[p] | re[p];
            end
        end
    end

endmodule

/* bank_ram.sv */
`timescale 1ns/1ps
`include "banked_mem_defines.svh"

module bank_ram (
    input  logic                    clk,
    input  logic                    we,
    input  mem_geom_pkg::mem_row_t  row,
    input  mem_geom_pkg::mem_word_t data,
    output mem_geom_pkg::mem_word_t q
);

    mem_geom_pkg::mem_word_t mem [2**`MEM_ROW_BITS];

    // single port, q holds its last read during a write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[row] <= data;
        end else begin
            q <= mem[row];
        end
    end

endmodule

/* mem_port_pkg.sv */
`include "banked_mem_defines.svh"

package mem_port_pkg;

    // byte address: thread on top, word offset below, byte bits ignored
    typedef logic [$clog2(`MEM_NUM_THREADS)+`MEM_ROW_BITS+
                   $clog2(`MEM_BANKS_PER_THREAD)+1:0] mem_addr_t;

    // thread region id
    typedef logic [$clog2(`MEM_NUM_THREADS)-1:0] mem_thread_t;

    // requester port number
    typedef logic [$clog2(`MEM_NUM_PORTS)-1:0] mem_port_idx_t;

endpackage

/* mem_geom_pkg.sv */
`include "banked_mem_defines.svh"

package mem_geom_pkg;

    // one word as stored in a bank
    typedef logic [31:0] mem_word_t;

    // full line, word 0 sits in the low bits
    typedef logic [`MEM_BANKS_PER_THREAD*32-1:0] mem_line_t;

    // row inside a single bank
    typedef logic [`MEM_ROW_BITS-1:0] mem_row_t;

    // bank number inside a region
    typedef logic [$clog2(`MEM_BANKS_PER_THREAD)-1:0] mem_bank_idx_t;

    // word offset inside a region, low bits select the bank
    typedef logic [`MEM_ROW_BITS+$clog2(`MEM_BANKS_PER_THREAD)-1:0] mem_word_ofs_t;

endpackage

/* banked_mem_defines.svh */
`ifndef BANKED_MEM_DEFINES_SVH
`define BANKED_MEM_DEFINES_SVH

// requester ports sharing the memory
`define MEM_NUM_PORTS 4

// thread regions, each with its own set of banks
`define MEM_NUM_THREADS 8

// banks in one region, also the words in one line
`define MEM_BANKS_PER_THREAD 4

// row address width of a single bank
`define MEM_ROW_BITS 6

// request edge to rd_rdy, in cycles
`define MEM_RD_LATENCY 5

`endif
